// File: logic/commit_unit.sv
// commit stage
// in order retirement and halt

`default_nettype none

`include "rob_params.svh"

module commit_unit import rob_pkg::*; (
	input  wire logic clock,
	input  wire logic reset,
	head_if.commit head,
	output logic commit_valid,
	output reg_idx_t commit_wr_idx,
	output logic commit_wr_en,
	output xlen_t commit_wr_data,
	output xlen_t commit_npc,
	output logic halted
);

	commit_state_e state;

	// one retirement per cycle, none once halted
	assign head.retire = head.ready && (state == commit_running);
	assign halted      = (state == commit_halted);

	////////////////////////////////////////////////////////////
	// fsm and strobes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state        <= commit_running;
			commit_valid <= 1'b0;
			commit_wr_en <= 1'b0;
		end else begin
			commit_valid <= head.retire;
			// write strobe only alongside a commit
			commit_wr_en <= head.retire && head.wr_en;
			case (state)
				commit_running: begin
					if (head.retire && head.halt) begin
						state <= commit_halted;
					end
				end
				// remaining entries are abandoned
				commit_halted: state <= commit_halted;
				default:       state <= commit_running;
			endcase
		end
	end

	// commit payload
	always_ff @(posedge clock) begin
		if (head.retire) begin
			commit_wr_idx  <= head.dest_reg;
			commit_wr_data <= head.value;
			commit_npc     <= head.npc;
		end
	end

endmodule

`default_nettype wire

// File: logic/issue_unit.sv
// issue stage
// decode and rob tag allocation

`default_nettype none

`include "rob_params.svh"

module issue_unit import rob_pkg::*; (
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic dispatch_valid,
	input  wire inst_t dispatch_inst,
	input  wire xlen_t dispatch_npc,
	output logic dispatch_ready,
	output tag_t dispatch_tag,
	input  wire logic retire_seen,
	input  wire logic halted,
	alloc_if.issue alloc
);

	// opcodes that never write a register
	localparam logic [6:0] opcode_store  = 7'b0100011;
	localparam logic [6:0] opcode_branch = 7'b1100011;

	// count of a completely full buffer
	localparam logic [`TAG_BITS:0] depth_count = `ROB_DEPTH;

	tag_t               tail;
	logic [`TAG_BITS:0] outstanding;
	logic               accept;

	logic [6:0] opcode;
	reg_idx_t   dec_dest;
	logic       dec_wr_en;
	logic       dec_halt;

	////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////

	assign opcode   = dispatch_inst[6:0];
	assign dec_dest = dispatch_inst[11:7];
	// x0 writes are dropped here so commit never sees them
	assign dec_wr_en = (opcode != opcode_store) && (opcode != opcode_branch) &&
		(dec_dest != '0);
	assign dec_halt = (dispatch_inst == `WFI_INST);

	////////////////////////////////////////////////////////////
	// flow control
	////////////////////////////////////////////////////////////

	// own count runs one cycle ahead of the rob count
	// since the allocation is registered
	assign dispatch_ready = !alloc.full && !halted && (outstanding != depth_count);
	assign accept         = dispatch_valid && dispatch_ready;
	assign dispatch_tag   = tail;

	always_ff @(posedge clock) begin
		if (reset) begin
			tail        <= '0;
			outstanding <= '0;
			alloc.valid <= 1'b0;
		end else begin
			alloc.valid <= accept;
			if (accept) begin
				// wraps modulo depth
				tail <= tail + 1'b1;
			end
			case ({accept, retire_seen})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	// allocation payload
	always_ff @(posedge clock) begin
		if (accept) begin
			alloc.tag      <= tail;
			alloc.dest_reg <= dec_dest;
			alloc.wr_en    <= dec_wr_en;
			alloc.npc      <= dispatch_npc;
			alloc.halt     <= dec_halt;
		end
	end

endmodule

`default_nettype wire

// File: logic/reorder_buffer.sv
// reorder buffer
// entry storage, completion write and head pointer

`default_nettype none

`include "rob_params.svh"

module reorder_buffer import rob_pkg::*; (
	input  wire logic clock,
	input  wire logic reset,
	alloc_if.rob alloc,
	input  wire logic complete_valid,
	input  wire tag_t complete_tag,
	input  wire xlen_t complete_value,
	head_if.rob head
);

	localparam logic [`TAG_BITS:0] depth_count = `ROB_DEPTH;

	// per entry flags
	logic [`ROB_DEPTH-1:0] busy;
	logic [`ROB_DEPTH-1:0] done;

	// entry payload
	reg_idx_t dest_mem  [`ROB_DEPTH];
	logic     wr_en_mem [`ROB_DEPTH];
	xlen_t    npc_mem   [`ROB_DEPTH];
	xlen_t    value_mem [`ROB_DEPTH];
	logic     halt_mem  [`ROB_DEPTH];

	tag_t               head_ptr;
	logic [`TAG_BITS:0] count;
	logic               complete_hit;

	// stray completions to free slots drop out here
	assign complete_hit = complete_valid && busy[complete_tag];

	assign alloc.full = (count == depth_count);

	////////////////////////////////////////////////////////////
	// flags and pointers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			busy     <= '0;
			done     <= '0;
			head_ptr <= '0;
			count    <= '0;
		end else begin
			if (alloc.valid) begin
				busy[alloc.tag] <= 1'b1;
				done[alloc.tag] <= 1'b0;
			end
			if (complete_hit) begin
				done[complete_tag] <= 1'b1;
			end
			// retire last so a freed head stays free
			if (head.retire) begin
				busy[head_ptr] <= 1'b0;
				done[head_ptr] <= 1'b0;
				head_ptr       <= head_ptr + 1'b1;
			end
			case ({alloc.valid, head.retire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// payload writes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (alloc.valid) begin
			dest_mem[alloc.tag]  <= alloc.dest_reg;
			wr_en_mem[alloc.tag] <= alloc.wr_en;
			npc_mem[alloc.tag]   <= alloc.npc;
			halt_mem[alloc.tag]  <= alloc.halt;
		end
		// result arrives in any order
		if (complete_hit) begin
			value_mem[complete_tag] <= complete_value;
		end
	end

	////////////////////////////////////////////////////////////
	// head view
	////////////////////////////////////////////////////////////

	assign head.ready    = busy[head_ptr] && done[head_ptr];
	assign head.dest_reg = dest_mem[head_ptr];
	assign head.wr_en    = wr_en_mem[head_ptr];
	assign head.value    = value_mem[head_ptr];
	assign head.npc      = npc_mem[head_ptr];
	assign head.halt     = halt_mem[head_ptr];

	// issue must hold off while the buffer is full
	a_no_alloc_when_full: assert property (
		@(posedge clock) disable iff (reset)
		alloc.valid |-> !alloc.full
	);

	// commit may only free a finished head
	a_retire_needs_ready: assert property (
		@(posedge clock) disable iff (reset)
		head.retire |-> head.ready
	);

endmodule

`default_nettype wire

// File: logic/rob_core.sv
// in order retirement core
// issue, reorder buffer and commit

`default_nettype none

`include "rob_params.svh"

module rob_core import rob_pkg::*; (
	input  wire logic clock,
	input  wire logic reset,

	// dispatch, valid/ready pair
	input  wire logic dispatch_valid,
	input  wire inst_t dispatch_inst,
	input  wire xlen_t dispatch_npc,
	output logic dispatch_ready,
	output tag_t dispatch_tag,

	// completion strobe, cannot be refused
	input  wire logic complete_valid,
	input  wire tag_t complete_tag,
	input  wire xlen_t complete_value,

	// retirement
	output logic commit_valid,
	output reg_idx_t commit_wr_idx,
	output logic commit_wr_en,
	output xlen_t commit_wr_data,
	output xlen_t commit_npc,
	output logic halted
);

	alloc_if alloc_bus ();
	head_if  head_bus ();

	////////////////////////////////////////////////////////////
	// issue
	////////////////////////////////////////////////////////////

	// retire feeds back so issue can track outstanding entries
	issue_unit issue0 (
		.clock          (clock),
		.reset          (reset),
		.dispatch_valid (dispatch_valid),
		.dispatch_inst  (dispatch_inst),
		.dispatch_npc   (dispatch_npc),
		.dispatch_ready (dispatch_ready),
		.dispatch_tag   (dispatch_tag),
		.retire_seen    (head_bus.retire),
		.halted         (halted),
		.alloc          (alloc_bus.issue)
	);

	////////////////////////////////////////////////////////////
	// reorder buffer
	////////////////////////////////////////////////////////////

	reorder_buffer rob0 (
		.clock          (clock),
		.reset          (reset),
		.alloc          (alloc_bus.rob),
		.complete_valid (complete_valid),
		.complete_tag   (complete_tag),
		.complete_value (complete_value),
		.head           (head_bus.rob)
	);

	////////////////////////////////////////////////////////////
	// commit
	////////////////////////////////////////////////////////////

	commit_unit commit0 (
		.clock          (clock),
		.reset          (reset),
		.head           (head_bus.commit),
		.commit_valid   (commit_valid),
		.commit_wr_idx  (commit_wr_idx),
		.commit_wr_en   (commit_wr_en),
		.commit_wr_data (commit_wr_data),
		.commit_npc     (commit_npc),
		.halted         (halted)
	);

endmodule

`default_nettype wire

// File: logic/rob_if.sv
// issue, rob and commit buses

`default_nettype none

`include "rob_params.svh"

// allocation from issue into the reorder buffer
interface alloc_if import rob_pkg::*; ();
	// one cycle strobe, entry written at this edge
	logic     valid;
	tag_t     tag;
	reg_idx_t dest_reg;
	logic     wr_en;
	xlen_t    npc;
	// entry is a wfi
	logic     halt;
	// occupancy at depth
	logic     full;

	modport issue (
		output valid, tag, dest_reg, wr_en, npc, halt,
		input  full
	);

	modport rob (
		input  valid, tag, dest_reg, wr_en, npc, halt,
		output full
	);
endinterface

// head entry from the reorder buffer to commit
interface head_if import rob_pkg::*; ();
	// head busy and done
	logic     ready;
	reg_idx_t dest_reg;
	logic     wr_en;
	xlen_t    value;
	xlen_t    npc;
	logic     halt;
	// frees the head at this edge
	logic     retire;

	modport rob (
		output ready, dest_reg, wr_en, value, npc, halt,
		input  retire
	);

	modport commit (
		input  ready, dest_reg, wr_en, value, npc, halt,
		output retire
	);
endinterface

`default_nettype wire

// File: logic/rob_params.svh
// reorder buffer core constants

`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// data path and npc width
`define XLEN 32

// number of reorder buffer entries
// must stay a power of two, tags wrap on their own
`define ROB_DEPTH 8

// tag width, log2 of depth
`define TAG_BITS 3

// architectural register index width
`define REG_BITS 5

// wfi instruction word, system opcode with rd = x0
`define WFI_INST 32'h1050_0073

`endif

// File: logic/rob_pkg.sv
// reorder buffer core types

`default_nettype none

`include "rob_params.svh"

package rob_pkg;

	////////////////////////////////////////////////////////////
	// value widths
	////////////////////////////////////////////////////////////

	// data or npc value
	typedef logic [`XLEN-1:0] xlen_t;

	// raw instruction word
	typedef logic [31:0] inst_t;

	// reorder buffer slot index
	typedef logic [`TAG_BITS-1:0] tag_t;

	// architectural register number
	typedef logic [`REG_BITS-1:0] reg_idx_t;

	////////////////////////////////////////////////////////////
	// commit fsm
	////////////////////////////////////////////////////////////

	// running retires in order, halted only leaves on reset
	typedef enum logic {
		commit_running,
		commit_halted
	} commit_state_e;

endpackage

`default_nettype wire

// File: tb.f
+incdir+logic
logic/rob_pkg.sv
logic/rob_if.sv
logic/issue_unit.sv
logic/reorder_buffer.sv
logic/commit_unit.sv
logic/rob_core.sv
tb/tb_rob_core.sv

// File: tb/tb_rob_core.sv
// reorder buffer core testbench

`default_nettype none

`include "rob_params.svh"

module tb_rob_core import rob_pkg::*; ();

	localparam int period = 40;

	localparam logic [6:0] op_alu    = 7'b0110011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	// opcode pool for random rows in 7 bit slices
	localparam logic [34:0] rand_ops = {op_alu, op_imm, op_load, op_store, op_branch};

	logic clock, reset;
	logic dispatch_valid, dispatch_ready, complete_valid;
	logic commit_valid, commit_wr_en, halted;
	inst_t dispatch_inst;
	xlen_t dispatch_npc, complete_value, commit_wr_data, commit_npc;
	tag_t dispatch_tag, complete_tag;
	reg_idx_t commit_wr_idx;

	////////////////////////////////////////////////////////////
	// stimulus table and reference model
	////////////////////////////////////////////////////////////

	inst_t tbl_inst [$];
	xlen_t tbl_npc [$];
	xlen_t tbl_value [$];
	int    tbl_rank [$];
	// first row of each group
	int    grp_first [$];
	// fill groups hold completions until the rob is full
	bit    grp_fill [$];
	int    grp_commits [$];
	tag_t  row_tag [0:127];

	// expected commits in program order
	xlen_t    exp_npc [$];
	xlen_t    exp_data [$];
	reg_idx_t exp_idx [$];
	logic     exp_wr_en [$];

	integer seed;
	bit     model_halted = 1'b0;
	bit     table_ready = 1'b0;
	tag_t   tag_expect = '0;
	int     accepted = 0;
	int     commits_seen = 0;
	int     errors = 0;

	rob_core dut0 (.*);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "value check failed");
		end
	endtask

	function automatic inst_t make_inst(logic [6:0] op, logic [4:0] rd);
		return {20'h00528, rd, op};
	endfunction

	// no write for store, branch or x0
	function automatic logic writes_reg(inst_t inst);
		return (inst[6:0] != op_store) && (inst[6:0] != op_branch) && (inst[11:7] != 5'd0);
	endfunction

	task automatic add_row(inst_t inst, xlen_t value, int rank);
		xlen_t npc;
		npc = 32'h0000_2000 + 4 * tbl_inst.size();
		tbl_inst.push_back(inst);
		tbl_npc.push_back(npc);
		tbl_value.push_back(value);
		tbl_rank.push_back(rank);
		// nothing retires past the first wfi
		if (!model_halted) begin
			exp_npc.push_back(npc);
			exp_data.push_back(value);
			exp_idx.push_back(inst[11:7]);
			exp_wr_en.push_back(writes_reg(inst));
		end
		if (inst == `WFI_INST) model_halted = 1'b1;
	endtask

	task automatic open_group(bit fill);
		grp_first.push_back(tbl_inst.size());
		grp_fill.push_back(fill);
	endtask

	task automatic close_group();
		grp_commits.push_back(exp_npc.size());
	endtask

	task automatic build_table();
		int n;
		int pick;
		int tmp;
		int perm [`ROB_DEPTH];
		// out of order results
		open_group(1'b0);
		add_row(make_inst(op_alu, 5'd1), 32'h1111_0001, 2);
		add_row(make_inst(op_imm, 5'd2), 32'h1111_0002, 0);
		add_row(make_inst(op_load, 5'd3), 32'h1111_0003, 3);
		add_row(make_inst(op_alu, 5'd4), 32'h1111_0004, 1);
		close_group();
		// decode rule with nonzero rd bits on store and branch
		open_group(1'b0);
		add_row(make_inst(op_store, 5'd5), 32'h2222_0001, 1);
		add_row(make_inst(op_branch, 5'd9), 32'h2222_0002, 4);
		add_row(make_inst(op_alu, 5'd0), 32'h2222_0003, 0);
		add_row(make_inst(op_imm, 5'd31), 32'h2222_0004, 3);
		add_row(make_inst(op_load, 5'd7), 32'h2222_0005, 2);
		close_group();
		// more than depth with the first eight finishing in reverse
		open_group(1'b1);
		for (int i = 0; i < 10; i++)
			add_row(make_inst(op_alu, 5'(i + 8)), 32'h3333_0000 + i, (i < 8) ? 7 - i : i);
		close_group();
		// random groups
		for (int g = 0; g < 3; g++) begin
			n = 1 + $unsigned($random(seed)) % `ROB_DEPTH;
			for (int i = 0; i < n; i++) perm[i] = i;
			for (int i = n - 1; i > 0; i--) begin
				pick = $unsigned($random(seed)) % (i + 1);
				tmp = perm[i];
				perm[i] = perm[pick];
				perm[pick] = tmp;
			end
			open_group(1'b0);
			for (int i = 0; i < n; i++) begin
				pick = $unsigned($random(seed)) % 5;
				add_row(make_inst(rand_ops[pick * 7 +: 7], 5'($random(seed))), $random(seed),
					perm[i]);
			end
			close_group();
		end
		// halt where the last row never commits
		open_group(1'b0);
		add_row(make_inst(op_alu, 5'd10), 32'h4444_0001, 2);
		add_row(`WFI_INST, 32'h4444_0002, 1);
		add_row(make_inst(op_alu, 5'd11), 32'h4444_0003, 0);
		close_group();
	endtask

	////////////////////////////////////////////////////////////
	// drivers
	////////////////////////////////////////////////////////////

	// entered just after a rising edge
	task automatic dispatch_row(int row);
		bit took;
		dispatch_valid = 1'b1;
		dispatch_inst  = tbl_inst[row];
		dispatch_npc   = tbl_npc[row];
		do begin
			@(negedge clock);
			took = dispatch_ready;
			if (took) begin
				compare($sformatf("dispatch_tag row %0d", row), tag_expect, dispatch_tag);
				row_tag[row] = tag_expect;
				tag_expect = tag_expect + 1'b1;
			end
			@(posedge clock);
			if (took) accepted++;
			#2;
		end while (!took);
		dispatch_valid = 1'b0;
	endtask

	// one edge of slack so the entry is busy first
	task automatic complete_row(int row);
		wait (accepted > row);
		@(posedge clock);
		#2;
		complete_valid = 1'b1;
		complete_tag   = row_tag[row];
		complete_value = tbl_value[row];
		@(posedge clock);
		#2;
		complete_valid = 1'b0;
	endtask

	task automatic run_group(int g);
		int first;
		int last;
		first = grp_first[g];
		last = (g + 1 < grp_first.size()) ? grp_first[g + 1] : tbl_inst.size();
		@(posedge clock);
		#2;
		fork
			for (int i = first; i < last; i++) dispatch_row(i);
			begin
				if (grp_fill[g]) begin
					wait (accepted == first + `ROB_DEPTH);
					repeat (4) @(negedge clock);
					compare("dispatch_ready with full rob", 0, dispatch_ready);
					compare("accepted with full rob", first + `ROB_DEPTH, accepted);
				end
				// completions by rank
				for (int r = 0; r < last - first; r++) begin
					for (int i = first; i < last; i++) begin
						if (tbl_rank[i] == r) complete_row(i);
					end
				end
			end
		join
		wait (commits_seen == grp_commits[g]);
	endtask

	////////////////////////////////////////////////////////////
	// commit monitor and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		@(negedge reset);
		forever begin
			@(negedge clock);
			if (commit_valid) begin
				if (exp_npc.size() == 0) begin
					$display("unexpected commit with npc %h", commit_npc);
					$display("RESULT: FAIL");
					$fatal(1, "commit without a pending instruction");
				end else begin
					compare($sformatf("commit %0d npc", commits_seen), exp_npc.pop_front(),
						commit_npc);
					compare($sformatf("commit %0d data", commits_seen), exp_data.pop_front(),
						commit_wr_data);
					compare($sformatf("commit %0d idx", commits_seen), exp_idx.pop_front(),
						commit_wr_idx);
					compare($sformatf("commit %0d wr_en", commits_seen), exp_wr_en.pop_front(),
						commit_wr_en);
					commits_seen++;
				end
			end
		end
	end

	// 50 cycles a row plus 200
	initial begin
		wait (table_ready);
		repeat (tbl_inst.size() * 50 + 200) @(posedge clock);
		$display("timeout, the tests did not finish in the allowed cycles");
		$display("RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		seed = 32'hdc20_809d;
		reset = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_inst = '0;
		dispatch_npc = '0;
		complete_valid = 1'b0;
		complete_tag = '0;
		complete_value = '0;
		build_table();
		table_ready = 1'b1;
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;
		// idle after reset
		repeat (5) begin
			@(negedge clock);
			compare("dispatch_ready after reset", 1, dispatch_ready);
			compare("halted after reset", 0, halted);
			compare("commit_valid while idle", 0, commit_valid);
			compare("dispatch_tag after reset", 0, dispatch_tag);
		end
		for (int g = 0; g < grp_first.size(); g++) run_group(g);
		// core stays halted once the wfi retires
		repeat (10) begin
			@(negedge clock);
			compare("halted after wfi", 1, halted);
			compare("dispatch_ready while halted", 0, dispatch_ready);
			compare("commit_valid while halted", 0, commit_valid);
		end
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
